// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ps
// Clock and reset source for the testbench.
// 40 ns clock, reset held low over the first 8 rising edges.

module tb_clk_gen (
  output logic clk,
  output logic arst_n_o
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (8) @(posedge clk);
    // Release away from the active edge
    @(negedge clk);
    arst_n_o = 1'b1;
  end

endmodule

// ==== bench/tb_uart_debug_server.sv ====
`timescale 1ns/1ps
// Testbench for the UART debug server. Plays the UART host, models a
// 256-byte Wishbone memory with random wait states, and checks every
// response byte, the memory contents and the exec request.

module tb_uart_debug_server
  import uart_pkg::*;
  import debug_pkg::*;
();

  logic        clk;
  logic        arst_n_i;
  logic        uart_rx_i = 1'b1;
  logic        uart_tx_o;
  logic        wb_cyc_o;
  logic        wb_stb_o;
  logic        wb_we_o;
  wb_addr_t    wb_adr_o;
  uart_byte_t  wb_dat_o;
  uart_byte_t  wb_dat_i = '0;
  logic        wb_ack_i = 1'b0;
  logic        exec_valid_o;
  wb_addr_t    exec_addr_o;

  logic [15:0] lfsr_state = 16'd52120;
  uart_byte_t  mem [256];
  uart_byte_t  mirror [256];
  uart_byte_t  exp_q [$];
  logic        in_access = 1'b0;
  int unsigned wait_left;
  wb_addr_t    exp_adr = '0;
  logic        mon_busy = 1'b0;
  int unsigned mon_cnt;
  uart_byte_t  mon_byte;
  logic        exec_armed = 1'b0;
  logic        exec_seen = 1'b0;
  wb_addr_t    exp_exec_addr;

  tb_clk_gen u_tb_clk_gen (
    .clk      ( clk      ),
    .arst_n_o ( arst_n_i )
  );

  uart_debug_server u_uart_debug_server (
    .clk          ( clk          ),
    .arst_n_i     ( arst_n_i     ),
    .uart_rx_i    ( uart_rx_i    ),
    .uart_tx_o    ( uart_tx_o    ),
    .wb_cyc_o     ( wb_cyc_o     ),
    .wb_stb_o     ( wb_stb_o     ),
    .wb_we_o      ( wb_we_o      ),
    .wb_adr_o     ( wb_adr_o     ),
    .wb_dat_o     ( wb_dat_o     ),
    .wb_dat_i     ( wb_dat_i     ),
    .wb_ack_i     ( wb_ack_i     ),
    .exec_valid_o ( exec_valid_o ),
    .exec_addr_o  ( exec_addr_o  )
  );

  //////////////////////////////////////////////////////////////////////
  // Random source, fill pattern and reference model
  //////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 16 14 13 11 and one step per bit
  function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    logic        fb;
    int          i;
    v = 0;
    for (i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      v = (v << 1) | fb;
    end
    return v;
  endfunction

  function automatic uart_byte_t fill_byte(input int idx);
    return uart_byte_t'(idx * 7 + 8'h5a);
  endfunction

  // Byte idx of a read from base within the wrapping 256-byte memory
  function automatic uart_byte_t ref_read_byte(input wb_addr_t base, input int idx);
    return mirror[8'(int'(base) + idx)];
  endfunction

  initial begin
    int i;
    for (i = 0; i < 256; i++) begin
      mem[i]    = fill_byte(i);
      mirror[i] = fill_byte(i);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
    if (got !== exp) begin
      report_failure($sformatf("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input wb_addr_t got, input wb_addr_t exp);
    if (got !== exp) begin
      report_failure($sformatf("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("[FAIL] t=%0t %s: got %b, expected %b", $time, name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Wishbone memory, response monitor and exec monitor
  //////////////////////////////////////////////////////////////////////

  // Zero to three wait states per access and a one-cycle ack
  always @(posedge clk) begin
    if (wb_ack_i) begin
      wb_ack_i <= 1'b0;
    end else if (wb_cyc_o === 1'b1 && wb_stb_o === 1'b1) begin
      if (!in_access) begin
        in_access = 1'b1;
        wait_left = rand_bits(2);
        check_addr("wb_adr_o", wb_adr_o, exp_adr);
        exp_adr = exp_adr + 1'b1;
      end
      if (wait_left != 0) begin
        wait_left--;
      end else begin
        in_access = 1'b0;
        wb_ack_i <= 1'b1;
        if (wb_we_o) begin
          mem[wb_adr_o[7:0]] = wb_dat_o;
        end else begin
          wb_dat_i <= mem[wb_adr_o[7:0]];
        end
      end
    end
  end

  // Decodes uart_tx_o at mid-bit and compares against the expected queue
  always @(posedge clk) begin
    int unsigned pos;
    if (arst_n_i !== 1'b1) begin
      mon_busy = 1'b0;
    end else if (!mon_busy) begin
      if (uart_tx_o === 1'b0) begin
        mon_busy = 1'b1;
        mon_cnt  = 0;
      end
    end else begin
      mon_cnt++;
      if (mon_cnt % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
        pos = mon_cnt / CLKS_PER_BIT;
        if (pos == 0) begin
          check_bit("uart_tx_o start bit", uart_tx_o, 1'b0);
        end else if (pos <= DATA_BITS) begin
          mon_byte[pos-1] = uart_tx_o;
        end else begin
          check_bit("uart_tx_o stop bit", uart_tx_o, 1'b1);
          mon_busy = 1'b0;
          if (exp_q.size() == 0) begin
            report_failure($sformatf("DUT sent byte %h when no response was due", mon_byte));
          end else begin
            check_byte("uart_tx_o", mon_byte, exp_q.pop_front());
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    if (exec_valid_o === 1'b1) begin
      if (!exec_armed) begin
        report_failure("exec_valid_o pulsed without a pending exec command");
      end else begin
        check_addr("exec_addr_o", exec_addr_o, exp_exec_addr);
        exec_armed = 1'b0;
        exec_seen  = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Host tasks
  //////////////////////////////////////////////////////////////////////

  task automatic send_byte(input uart_byte_t b);
    logic [FRAME_BITS-1:0] frame;
    int                    i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < FRAME_BITS; i++) begin
      @(posedge clk);
      uart_rx_i <= frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  // Little-endian 8-byte field
  task automatic send_field(input logic [63:0] v);
    int k;
    for (k = 0; k < FIELD_BYTES; k++) begin
      send_byte(v[8*k +: 8]);
    end
  endtask

  task automatic wait_responses();
    int limit;
    int cnt;
    limit = (exp_q.size() + 2) * (FRAME_BITS + 2) * CLKS_PER_BIT;
    cnt   = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      cnt++;
      if (cnt > limit) begin
        report_failure("Timed out waiting for response bytes from the DUT");
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          i;
    int          n;
    int          cnt;
    wb_addr_t    base;
    logic [63:0] addr_field;
    logic [63:0] len_field;
    uart_byte_t  d;

    cnt = 0;
    while (arst_n_i !== 1'b1) begin
      @(negedge clk);
      cnt++;
      if (cnt > 100) begin
        report_failure("Reset was never released");
      end
    end
    for (i = 0; i < 20; i++) begin
      @(negedge clk);
      check_bit("uart_tx_o", uart_tx_o, 1'b1);
      check_bit("wb_cyc_o", wb_cyc_o, 1'b0);
      check_bit("exec_valid_o", exec_valid_o, 1'b0);
    end

    // ACK challenge
    exp_q.push_back(OP_ACK);
    send_byte(OP_ACK);
    wait_responses();

    // Write N random bytes with junk in the upper field bytes
    n = 1 + rand_bits(4);
    addr_field[63:32] = rand_bits(32);
    addr_field[31:0]  = rand_bits(32);
    base = addr_field[ADDR_W-1:0];
    len_field[63:32] = rand_bits(32);
    len_field[31:16] = 16'(rand_bits(16));
    len_field[15:0]  = 16'(n);
    exp_adr = base;
    exp_q.push_back(OP_ACK);
    send_byte(OP_WRITE);
    send_field(addr_field);
    send_field(len_field);
    wait_responses();
    exp_q.push_back(OP_EOT);
    for (i = 0; i < n; i++) begin
      d = uart_byte_t'(rand_bits(8));
      mirror[8'(int'(base) + i)] = d;
      send_byte(d);
    end
    wait_responses();
    for (i = 0; i < 256; i++) begin
      check_byte($sformatf("mem[%0d]", i), mem[i], mirror[i]);
    end

    // Read the same bytes back
    exp_adr = base;
    exp_q.push_back(OP_ACK);
    for (i = 0; i < n; i++) begin
      exp_q.push_back(ref_read_byte(base, i));
    end
    exp_q.push_back(OP_EOT);
    send_byte(OP_READ);
    send_field(addr_field);
    send_field(len_field);
    wait_responses();

    // Zero-length read
    addr_field[31:0] = rand_bits(32);
    len_field[15:0]  = 16'd0;
    exp_q.push_back(OP_ACK);
    exp_q.push_back(OP_EOT);
    send_byte(OP_READ);
    send_field(addr_field);
    send_field(len_field);
    wait_responses();

    // Exec request
    addr_field[63:32] = rand_bits(32);
    addr_field[31:0]  = rand_bits(32);
    exp_exec_addr = addr_field[ADDR_W-1:0];
    exec_armed    = 1'b1;
    exp_q.push_back(OP_ACK);
    send_byte(OP_EXEC);
    send_field(addr_field);
    wait_responses();
    cnt = 0;
    while (!exec_seen) begin
      @(negedge clk);
      cnt++;
      if (cnt > 4 * CLKS_PER_BIT) begin
        report_failure("exec_valid_o never pulsed after the exec command");
      end
    end

    // Stray byte that must stay unanswered
    send_byte(8'h55);
    repeat (3 * FRAME_BITS * CLKS_PER_BIT) @(negedge clk);
    exp_q.push_back(OP_ACK);
    send_byte(OP_ACK);
    wait_responses();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== design/debug_engine.sv ====
`timescale 1ns/1ps
// Debug command engine behind the UART. Parses ACK challenges and read,
// write and exec commands, moves data over a Wishbone classic master
// and answers through the transmitter's valid/ready input.

module debug_engine
  import uart_pkg::*;
  import debug_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n_i,
  input  uart_byte_t rx_byte_i,
  input  logic       rx_valid_i,
  output uart_byte_t tx_byte_o,
  output logic       tx_valid_o,
  input  logic       tx_ready_i,
  output logic       wb_cyc_o,
  output logic       wb_stb_o,
  output logic       wb_we_o,
  output wb_addr_t   wb_adr_o,
  output uart_byte_t wb_dat_o,
  input  uart_byte_t wb_dat_i,
  input  logic       wb_ack_i,
  output logic       exec_valid_o,
  output wb_addr_t   exec_addr_o
);

  dbg_state_e             state;
  dbg_opcode_e            cmd;
  logic [FIELD_CNT_W-1:0] field_cnt;
  logic                   field_last;
  wb_addr_t               addr;
  xfer_len_t              remain;
  uart_byte_t             data_q;
  logic                   tx_fire;

  assign field_last = field_cnt == FIELD_CNT_W'(FIELD_BYTES - 1);
  assign tx_fire    = tx_valid_o & tx_ready_i;

  // Address counter serves both the bus and the exec request
  assign wb_adr_o     = addr;
  assign wb_dat_o     = data_q;
  assign exec_addr_o  = addr;
  assign exec_valid_o = state == ST_EXEC;

  //////////////////////////////////////////////////////////////////////
  // Response byte
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    tx_valid_o = 1'b0;
    tx_byte_o  = data_q;
    case (state)
      ST_SEND_ACK: begin
        tx_valid_o = 1'b1;
        tx_byte_o  = OP_ACK;
      end
      ST_RD_SEND: begin
        tx_valid_o = 1'b1;
      end
      ST_SEND_EOT: begin
        tx_valid_o = 1'b1;
        tx_byte_o  = OP_EOT;
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // FSM and bus control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state     <= ST_IDLE;
      field_cnt <= '0;
      wb_cyc_o  <= 1'b0;
      wb_stb_o  <= 1'b0;
      wb_we_o   <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          // Anything that is not an opcode is dropped here
          if (rx_valid_i) begin
            field_cnt <= '0;
            case (rx_byte_i)
              OP_ACK: state <= ST_SEND_ACK;
              OP_READ, OP_WRITE, OP_EXEC: state <= ST_ADDR;
              default: state <= ST_IDLE;
            endcase
          end
        end
        ST_ADDR, ST_LEN: begin
          if (rx_valid_i) begin
            field_cnt <= field_last ? '0 : field_cnt + 1'b1;
            if (field_last) begin
              // Exec carries no length field
              if (state == ST_LEN || cmd == OP_EXEC) begin
                state <= ST_SEND_ACK;
              end else begin
                state <= ST_LEN;
              end
            end
          end
        end
        ST_SEND_ACK: begin
          if (tx_fire) begin
            wb_we_o <= cmd == OP_WRITE;
            case (cmd)
              OP_READ: begin
                if (remain == '0) begin
                  state <= ST_SEND_EOT;
                end else begin
                  state    <= ST_BUS;
                  wb_cyc_o <= 1'b1;
                  wb_stb_o <= 1'b1;
                end
              end
              OP_WRITE: state <= (remain == '0) ? ST_SEND_EOT : ST_WR_DATA;
              OP_EXEC: state <= ST_EXEC;
              default: state <= ST_IDLE;
            endcase
          end
        end
        ST_WR_DATA: begin
          if (rx_valid_i) begin
            state    <= ST_BUS;
            wb_cyc_o <= 1'b1;
            wb_stb_o <= 1'b1;
          end
        end
        ST_BUS: begin
          // Single access, released in the cycle after its ack
          if (wb_ack_i) begin
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            if (!wb_we_o) begin
              state <= ST_RD_SEND;
            end else if (remain == xfer_len_t'(1)) begin
              state <= ST_SEND_EOT;
            end else begin
              state <= ST_WR_DATA;
            end
          end
        end
        ST_RD_SEND: begin
          // Count already holds the bytes left after this one
          if (tx_fire) begin
            if (remain == '0) begin
              state <= ST_SEND_EOT;
            end else begin
              state    <= ST_BUS;
              wb_cyc_o <= 1'b1;
              wb_stb_o <= 1'b1;
            end
          end
        end
        ST_SEND_EOT: begin
          if (tx_fire) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    case (state)
      ST_IDLE: begin
        if (rx_valid_i) begin
          cmd <= dbg_opcode_e'(rx_byte_i);
        end
      end
      ST_ADDR: begin
        // Little-endian with the upper field bytes ignored
        if (rx_valid_i && field_cnt < FIELD_CNT_W'(ADDR_BYTES)) begin
          addr <= {rx_byte_i, addr[ADDR_W-1:8]};
        end
      end
      ST_LEN: begin
        if (rx_valid_i && field_cnt < FIELD_CNT_W'(LEN_BYTES)) begin
          remain <= {rx_byte_i, remain[LEN_W-1:8]};
        end
      end
      ST_WR_DATA: begin
        if (rx_valid_i) begin
          data_q <= rx_byte_i;
        end
      end
      ST_BUS: begin
        if (wb_ack_i) begin
          addr   <= addr + 1'b1;
          remain <= remain - 1'b1;
          if (!wb_we_o) begin
            data_q <= wb_dat_i;
          end
        end
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n_i)
    wb_stb_o |-> wb_cyc_o);

  // Request stays put until the slave acks it
  a_adr_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o));

  a_exec_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
    exec_valid_o |=> !exec_valid_o);

endmodule

// ==== design/debug_pkg.sv ====
// Protocol opcodes, engine states and bus widths of the UART debug engine.
// The host speaks little-endian 8-byte address and length fields; only
// the low ADDR_W and LEN_W bits of them reach the hardware.

package debug_pkg;

  //////////////////////////////////////////////////////////////////////
  // Protocol bytes
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [7:0] {
    OP_EOT   = 8'h04,
    OP_ACK   = 8'h06,
    OP_READ  = 8'h11,
    OP_WRITE = 8'h12,
    OP_EXEC  = 8'h13
  } dbg_opcode_e;

  // Engine FSM
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_ADDR,
    ST_LEN,
    ST_SEND_ACK,
    ST_WR_DATA,
    ST_BUS,
    ST_RD_SEND,
    ST_SEND_EOT,
    ST_EXEC
  } dbg_state_e;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int ADDR_W = 16;
  localparam int LEN_W = 16;

  // Bytes per address or length field on the wire
  localparam int FIELD_BYTES = 8;
  localparam int FIELD_CNT_W = $clog2(FIELD_BYTES);

  // Leading field bytes that are kept
  localparam int ADDR_BYTES = ADDR_W / 8;
  localparam int LEN_BYTES = LEN_W / 8;

  typedef logic [ADDR_W-1:0] wb_addr_t;
  typedef logic [LEN_W-1:0] xfer_len_t;

endpackage

// ==== design/uart_debug_server.sv ====
`timescale 1ns/1ps
// Top level of the UART debug server. The host talks to it over one
// UART line pair; memory is reached through an 8-bit Wishbone master,
// and an exec command raises a one-cycle request with its entry address.

module uart_debug_server
  import uart_pkg::*;
  import debug_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n_i,
  input  logic       uart_rx_i,
  output logic       uart_tx_o,
  output logic       wb_cyc_o,
  output logic       wb_stb_o,
  output logic       wb_we_o,
  output wb_addr_t   wb_adr_o,
  output uart_byte_t wb_dat_o,
  input  uart_byte_t wb_dat_i,
  input  logic       wb_ack_i,
  output logic       exec_valid_o,
  output wb_addr_t   exec_addr_o
);

  uart_byte_t rx_byte;
  logic       rx_valid;
  uart_byte_t tx_byte;
  logic       tx_valid;
  logic       tx_ready;

  // Host to server line
  uart_rx u_uart_rx (
    .clk        ( clk       ),
    .arst_n_i   ( arst_n_i  ),
    .rx_i       ( uart_rx_i ),
    .rx_byte_o  ( rx_byte   ),
    .rx_valid_o ( rx_valid  )
  );

  debug_engine u_debug_engine (
    .clk          ( clk          ),
    .arst_n_i     ( arst_n_i     ),
    .rx_byte_i    ( rx_byte      ),
    .rx_valid_i   ( rx_valid     ),
    .tx_byte_o    ( tx_byte      ),
    .tx_valid_o   ( tx_valid     ),
    .tx_ready_i   ( tx_ready     ),
    .wb_cyc_o     ( wb_cyc_o     ),
    .wb_stb_o     ( wb_stb_o     ),
    .wb_we_o      ( wb_we_o      ),
    .wb_adr_o     ( wb_adr_o     ),
    .wb_dat_o     ( wb_dat_o     ),
    .wb_dat_i     ( wb_dat_i     ),
    .wb_ack_i     ( wb_ack_i     ),
    .exec_valid_o ( exec_valid_o ),
    .exec_addr_o  ( exec_addr_o  )
  );

  // Server to host line
  uart_tx u_uart_tx (
    .clk        ( clk       ),
    .arst_n_i   ( arst_n_i  ),
    .tx_byte_i  ( tx_byte   ),
    .tx_valid_i ( tx_valid  ),
    .tx_ready_o ( tx_ready  ),
    .tx_o       ( uart_tx_o )
  );

endmodule

// ==== design/uart_pkg.sv ====
// Bit timing and frame constants for the UART side of the debug server.
// Shared by the 8N1 receiver, the transmitter and the testbench host model.
// Modules take it by a wildcard import in their header.

package uart_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bit timing
  //////////////////////////////////////////////////////////////////////

  // Clock cycles per UART bit
  localparam int CLKS_PER_BIT = 16;

  // Data bits per frame, no parity
  localparam int DATA_BITS = 8;

  // Start bit, data bits and one stop bit
  localparam int FRAME_BITS = DATA_BITS + 2;

  // Counter widths for the bit timers
  // Receiver waits up to 1.5 bit times after the start edge
  localparam int CLK_CNT_W = $clog2(2 * CLKS_PER_BIT);
  localparam int BIT_CNT_W = $clog2(FRAME_BITS);

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [DATA_BITS-1:0] uart_byte_t;

endpackage

// ==== design/uart_rx.sv ====
`timescale 1ns/1ps
// UART 8N1 receiver. Samples each data bit in its middle and strobes
// rx_valid_o for one cycle in the middle of a good stop bit.
// No back-pressure: the consumer must take the byte in that cycle.

module uart_rx import uart_pkg::*; (
  input  logic       clk,
  input  logic       arst_n_i,
  input  logic       rx_i,
  output uart_byte_t rx_byte_o,
  output logic       rx_valid_o
);

  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_prev;
  logic                 busy;
  logic [CLK_CNT_W-1:0] clk_cnt;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic                 start_edge;
  logic                 sample;
  logic                 data_phase;
  uart_byte_t           shift_q;

  // Falling edge on the synchronized line while idle opens a frame
  assign start_edge = rx_prev & ~rx_sync;
  assign sample     = busy && (clk_cnt == '0);
  assign data_phase = bit_cnt < BIT_CNT_W'(DATA_BITS);

  // Two-flop synchronizer plus one delayed copy for edge detection
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy       <= 1'b0;
      clk_cnt    <= '0;
      bit_cnt    <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      if (!busy) begin
        if (start_edge) begin
          busy    <= 1'b1;
          bit_cnt <= '0;
          // First data sample 1.5 bit times after the edge
          clk_cnt <= CLK_CNT_W'(CLKS_PER_BIT + CLKS_PER_BIT / 2 - 1);
        end
      end else if (clk_cnt != '0) begin
        clk_cnt <= clk_cnt - 1'b1;
      end else if (data_phase) begin
        bit_cnt <= bit_cnt + 1'b1;
        clk_cnt <= CLK_CNT_W'(CLKS_PER_BIT - 1);
      end else begin
        // Middle of the stop bit, a low line means a framing error
        busy       <= 1'b0;
        rx_valid_o <= rx_sync;
      end
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (sample && data_phase) begin
      shift_q <= {rx_sync, shift_q[DATA_BITS-1:1]};
    end
  end

  assign rx_byte_o = shift_q;

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps
// UART 8N1 transmitter with a valid/ready byte input.
// A byte is taken when tx_valid_i and tx_ready_o are both high; the line
// then carries one frame and tx_ready_o stays low until it is done.

module uart_tx import uart_pkg::*; (
  input  logic       clk,
  input  logic       arst_n_i,
  input  uart_byte_t tx_byte_i,
  input  logic       tx_valid_i,
  output logic       tx_ready_o,
  output logic       tx_o
);

  logic                  busy;
  logic [CLK_CNT_W-1:0]  clk_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [FRAME_BITS-1:0] frame;

  assign tx_ready_o = ~busy;

  // Bit 0 of the frame register is the line, ones shift in behind it
  assign tx_o = frame[0];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
      frame   <= '1;
    end else if (!busy) begin
      if (tx_valid_i) begin
        busy    <= 1'b1;
        clk_cnt <= CLK_CNT_W'(CLKS_PER_BIT - 1);
        bit_cnt <= BIT_CNT_W'(FRAME_BITS - 1);
        // Stop bit, data LSB first, start bit
        frame   <= {1'b1, tx_byte_i, 1'b0};
      end
    end else if (clk_cnt != '0) begin
      clk_cnt <= clk_cnt - 1'b1;
    end else if (bit_cnt != '0) begin
      bit_cnt <= bit_cnt - 1'b1;
      clk_cnt <= CLK_CNT_W'(CLKS_PER_BIT - 1);
      frame   <= {1'b1, frame[FRAME_BITS-1:1]};
    end else begin
      // End of the stop bit
      busy <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Sender must hold its offer while the frame is still going out
  a_byte_held: assert property (@(posedge clk) disable iff (!arst_n_i)
    tx_valid_i && !tx_ready_o |=> tx_valid_i && $stable(tx_byte_i));

endmodule

// ==== src.f ====
design/uart_pkg.sv
design/debug_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/debug_engine.sv
design/uart_debug_server.sv
bench/tb_clk_gen.sv
bench/tb_uart_debug_server.sv
